// ==== src.f ====
design/phoenix_pkg.sv
design/hall_shift_reader.sv
design/stop_deglitch.sv
design/pwm_trigger_gen.sv
design/commutation_pwm.sv
design/wb_regs.sv
design/phoenix_top.sv
dv/tb_phoenix.sv

// ==== Makefile ====
TOP := tb_phoenix

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) -f src.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== dv/tb_phoenix.sv ====
`timescale 1ns/10ps

module tb_phoenix;
    import phoenix_pkg::*;

    localparam int ACK_TIMEOUT   = 8;
    localparam int PERIOD_WINDOW = 3100;

    logic                  CLK25MHz;
    logic                  reset_150mhz;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [1:0]            wb_adr;
    logic [15:0]           wb_dat_w;
    logic [15:0]           wb_dat_r;
    logic                  wb_ack;
    logic                  HALL1_DOUT;
    logic                  HALL2_DOUT;
    logic                  FPGA_STOP_N;
    logic                  adc_sample_valid;
    logic                  MOTOR5_FAULT_N;
    logic                  MOTOR5_OTW_N;
    logic [NUM_MOTORS-1:0] sw_flt_n;
    logic                  HALL1_CLK;
    logic                  HALL1_LOAD_N;
    logic                  HALL2_CLK;
    logic                  HALL2_LOAD_N;
    logic [NUM_MOTORS-1:0] motor_led;
    logic [NUM_MOTORS-1:0] motor_sw_en;
    logic [2:0]            motor5_pwm;
    logic [2:0]            motor5_reset_n;

    // sensor states, 1 means the sensor is active
    // sense1 index 0..7 is stage A..H, sense2 index 8 is the serial input
    logic [7:0] sense1 = '0;
    logic [8:0] sense2 = '0;
    logic [7:0] chain1 = 8'hff;
    logic [7:0] chain2 = 8'hff;

    logic [15:0] lfsr_state;
    string       test_name;
    logic        test_failed;
    int          pass_count;
    int          fail_count;

    // stimulus table, one entry per row in each queue
    string       row_name[$];
    logic [2:0]  row_hall[$];
    logic [15:0] row_duty[$];
    logic        row_fault[$];
    logic        row_brake[$];
    logic [2:0]  row_reset_n[$];
    logic [2:0]  row_switch[$];
    logic [15:0] row_on[$];

    phoenix_top dut (.*);

    initial begin
        CLK25MHz = 1'b0;
        forever #20 CLK25MHz = ~CLK25MHz;
    end

    // parallel-in shift registers, load while low, shift on rising clock
    always @(negedge HALL1_LOAD_N or posedge HALL1_CLK) begin
        if (!HALL1_LOAD_N) begin
            chain1 <= ~sense1;
        end else begin
            chain1 <= {chain1[6:0], 1'b1};
        end
    end

    always @(negedge HALL2_LOAD_N or posedge HALL2_CLK) begin
        if (!HALL2_LOAD_N) begin
            chain2 <= ~sense2[7:0];
        end else begin
            chain2 <= {chain2[6:0], ~sense2[8]};
        end
    end

    assign HALL1_DOUT = chain1[7];
    assign HALL2_DOUT = chain2[7];

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    task automatic take_random(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_failed = 1'b0;
    endtask

    task automatic finish_test();
        if (test_failed) begin
            fail_count++;
            $display("FAIL %s", test_name);
        end else begin
            pass_count++;
            $display("PASS %s", test_name);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        test_failed = 1'b1;
    endtask

    task automatic check_equal(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_failed = 1'b1;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
        int cycles = 0;
        rdata = '0;
        @(posedge CLK25MHz);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge CLK25MHz);
        while (!wb_ack && cycles < ACK_TIMEOUT) begin
            @(negedge CLK25MHz);
            cycles++;
        end
        assert (wb_ack) else report_failure("timeout, the slave never raised its ack");
        rdata = wb_dat_r;
        @(posedge CLK25MHz);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [15:0] data);
        logic [15:0] ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [15:0] data);
        bus_cycle(1'b0, adr, 16'h0000, data);
    endtask

    // repeats status reads until the masked field matches or reads run out
    task automatic poll_status(input logic [15:0] mask, input logic [15:0] expected,
                               input int max_reads, output logic [15:0] status);
        int reads = 0;
        read_reg(ADDR_STATUS, status);
        while (((status & mask) != expected) && reads < max_reads) begin
            read_reg(ADDR_STATUS, status);
            reads++;
        end
    endtask

    task automatic strobe_adc(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge CLK25MHz);
            adc_sample_valid <= 1'b1;
            @(posedge CLK25MHz);
            adc_sample_valid <= 1'b0;
        end
    endtask

    task automatic add_row(input string name, input logic [2:0] hall, input logic [15:0] duty,
                           input logic fault, input logic brake, input logic [2:0] reset_n,
                           input logic [2:0] switching, input logic [15:0] on_time);
        row_name.push_back(name);
        row_hall.push_back(hall);
        row_duty.push_back(duty);
        row_fault.push_back(fault);
        row_brake.push_back(brake);
        row_reset_n.push_back(reset_n);
        row_switch.push_back(switching);
        row_on.push_back(on_time);
    endtask

    initial begin
        logic [15:0] rnd;
        logic [15:0] status;
        logic [15:0] expected;
        logic [2:0]  hall;
        logic        stop_seen;
        logic        stray;
        int          high_count;

        wb_cyc           = 1'b0;
        wb_stb           = 1'b0;
        wb_we            = 1'b0;
        wb_adr           = 2'b00;
        wb_dat_w         = 16'h0000;
        FPGA_STOP_N      = 1'b1;
        adc_sample_valid = 1'b0;
        MOTOR5_FAULT_N   = 1'b1;
        MOTOR5_OTW_N     = 1'b1;
        sw_flt_n         = '1;
        lfsr_state       = 16'd6796;
        pass_count       = 0;
        fail_count       = 0;
        reset_150mhz     = 1'b1;
        repeat (2) @(posedge CLK25MHz);
        reset_150mhz <= 1'b0;

        // reset_n and switching phase in w,v,u order
        add_row("uv_fwd",      3'b101, 16'd1000,   1'b0, 1'b0, 3'b011, 3'b001, 16'd1000);
        add_row("uw_fwd",      3'b100, 16'd500,    1'b0, 1'b0, 3'b101, 3'b001, 16'd500);
        add_row("vw_max",      3'b110, 16'd2985,   1'b0, 1'b0, 3'b110, 3'b010, 16'd2985);
        add_row("vu_clamp",    3'b010, 16'd4000,   1'b0, 1'b0, 3'b011, 3'b010, 16'd2985);
        add_row("wu_one",      3'b011, 16'd1,      1'b0, 1'b0, 3'b101, 3'b100, 16'd1);
        add_row("wv_zero",     3'b001, 16'd0,      1'b0, 1'b0, 3'b110, 3'b100, 16'd0);
        add_row("uv_rev",      3'b101, -16'sd700,  1'b0, 1'b0, 3'b011, 3'b010, 16'd700);
        add_row("wu_rev",      3'b011, -16'sd3000, 1'b0, 1'b0, 3'b101, 3'b001, 16'd2985);
        add_row("hall_000",    3'b000, 16'd1200,   1'b0, 1'b0, 3'b000, 3'b000, 16'd0);
        add_row("hall_111",    3'b111, 16'd1200,   1'b0, 1'b0, 3'b000, 3'b000, 16'd0);
        add_row("fault",       3'b101, 16'd1500,   1'b1, 1'b0, 3'b000, 3'b000, 16'd0);
        add_row("brake",       3'b110, 16'd1500,   1'b0, 1'b1, 3'b111, 3'b000, 16'd0);
        add_row("fault_brake", 3'b100, 16'd1500,   1'b1, 1'b1, 3'b000, 3'b000, 16'd0);
        // most negative duty still clamps
        add_row("vu_min_duty", 3'b010, 16'h8000,   1'b0, 1'b0, 3'b011, 3'b001, 16'd2985);

        start_test("reg_reset");
        read_reg(ADDR_CTRL, rnd);
        check_equal("ctrl", 16'h001f, rnd);
        finish_test();

        start_test("reg_access");
        for (int n = 0; n < 3; n++) begin
            take_random(10, rnd);
            expected = {6'b000000, rnd[9:0]};
            write_reg(ADDR_CTRL, expected);
            @(negedge CLK25MHz);
            check_equal("motor_led", {11'b0, expected[4:0]}, {11'b0, motor_led});
            check_equal("motor_sw_en", {11'b0, expected[9:5]}, {11'b0, motor_sw_en});
            read_reg(ADDR_CTRL, rnd);
            check_equal("ctrl readback", expected, rnd);
            take_random(16, expected);
            write_reg(ADDR_DUTY, expected);
            read_reg(ADDR_DUTY, rnd);
            check_equal("duty readback", expected, rnd);
        end
        finish_test();

        start_test("hall_scan");
        for (int n = 0; n < 4; n++) begin
            take_random(16, rnd);
            @(posedge CLK25MHz);
            sense1         <= rnd[7:0];
            sw_flt_n       <= rnd[12:8];
            MOTOR5_FAULT_N <= rnd[13];
            MOTOR5_OTW_N   <= rnd[14];
            take_random(9, expected);
            sense2 <= expected[8:0];
            expected = {2'b00, ~rnd[12:8], ~rnd[14], ~rnd[13], 1'b0,
                        expected[7], expected[0], expected[8], rnd[2:0]};
            poll_status(16'hffff, expected, 40, status);
            check_equal("status", expected, status);
        end
        @(posedge CLK25MHz);
        sw_flt_n       <= '1;
        MOTOR5_FAULT_N <= 1'b1;
        MOTOR5_OTW_N   <= 1'b1;
        finish_test();

        start_test("stop_glitch");
        stop_seen = 1'b0;
        @(posedge CLK25MHz);
        FPGA_STOP_N <= 1'b0;
        // status is read during the pulse and after it
        fork
            begin
                repeat (50) @(posedge CLK25MHz);
                FPGA_STOP_N <= 1'b1;
            end
            begin
                for (int n = 0; n < 60; n++) begin
                    read_reg(ADDR_STATUS, status);
                    if (status[6]) begin
                        stop_seen = 1'b1;
                    end
                end
            end
        join
        check_equal("stop bit", 16'h0000, {15'b0, stop_seen});
        finish_test();

        start_test("stop_hold");
        @(posedge CLK25MHz);
        FPGA_STOP_N <= 1'b0;
        repeat (300) @(posedge CLK25MHz);
        read_reg(ADDR_STATUS, status);
        check_equal("stop bit held", 16'h0040, status & 16'h0040);
        @(posedge CLK25MHz);
        FPGA_STOP_N <= 1'b1;
        poll_status(16'h0040, 16'h0000, 100, status);
        check_equal("stop bit released", 16'h0000, status & 16'h0040);
        finish_test();

        for (int i = 0; i < row_name.size(); i++) begin
            start_test(row_name[i]);
            hall = row_hall[i];
            take_random(6, rnd);
            // u on stage H, v on stage A, w on the serial input
            @(posedge CLK25MHz);
            sense2 <= {hall[0], hall[2], rnd[5:0], hall[1]};
            poll_status(16'h0038, {10'b0, hall, 3'b000}, 40, status);
            check_equal("motor 5 hall", {10'b0, hall, 3'b000}, status & 16'h0038);
            write_reg(ADDR_DUTY, row_duty[i]);
            write_reg(ADDR_FAULT, {14'b0, row_brake[i], row_fault[i]});
            strobe_adc(30);
            high_count = 0;
            stray      = 1'b0;
            repeat (PERIOD_WINDOW) begin
                @(negedge CLK25MHz);
                if ((motor5_pwm & row_switch[i]) != 3'b000) begin
                    high_count++;
                end
                if ((motor5_pwm & ~row_switch[i]) != 3'b000) begin
                    stray = 1'b1;
                end
            end
            check_equal("on-time", row_on[i], 16'(high_count));
            check_equal("motor5_reset_n", {13'b0, row_reset_n[i]}, {13'b0, motor5_reset_n});
            assert (!stray) else report_failure("a phase other than the switching one went high");
            finish_test();
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== design/phoenix_top.sv ====
`timescale 1ns/10ps

module phoenix_top (
    input  logic                               CLK25MHz,
    input  logic                               reset_150mhz,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [1:0]                         wb_adr,
    input  logic [15:0]                        wb_dat_w,
    output logic [15:0]                        wb_dat_r,
    output logic                               wb_ack,
    input  logic                               HALL1_DOUT,
    input  logic                               HALL2_DOUT,
    input  logic                               FPGA_STOP_N,
    input  logic                               adc_sample_valid,
    input  logic                               MOTOR5_FAULT_N,
    input  logic                               MOTOR5_OTW_N,
    input  logic [phoenix_pkg::NUM_MOTORS-1:0] sw_flt_n,
    output logic                               HALL1_CLK,
    output logic                               HALL1_LOAD_N,
    output logic                               HALL2_CLK,
    output logic                               HALL2_LOAD_N,
    output logic [phoenix_pkg::NUM_MOTORS-1:0] motor_led,
    output logic [phoenix_pkg::NUM_MOTORS-1:0] motor_sw_en,
    output logic [2:0]                         motor5_pwm,
    output logic [2:0]                         motor5_reset_n
);
    import phoenix_pkg::*;

    logic [HALL1_BITS-1:0]        hall1_bits;
    logic [HALL2_BITS-1:0]        hall2_bits;
    logic [2:0]                   motor5_hall_uvw;
    logic                         stop_n_filtered;
    logic                         pwm_trigger;
    logic signed [DUTY_WIDTH-1:0] pwm_duty;
    logic                         pwm_fault;
    logic                         pwm_brake;

    // dribble motor hall is H, A and SER of chain 2
    assign motor5_hall_uvw = {hall2_bits[HALL2_BITS-1], hall2_bits[1], hall2_bits[0]};

    hall_shift_reader #(.NUM_BITS(HALL1_BITS)) u_hall1 (
        .CLK25MHz, .reset_150mhz,
        .sr_dout   (HALL1_DOUT),
        .sr_load_n (HALL1_LOAD_N),
        .sr_clk    (HALL1_CLK),
        .hall_bits (hall1_bits)
    );

    hall_shift_reader #(.NUM_BITS(HALL2_BITS)) u_hall2 (
        .CLK25MHz, .reset_150mhz,
        .sr_dout   (HALL2_DOUT),
        .sr_load_n (HALL2_LOAD_N),
        .sr_clk    (HALL2_CLK),
        .hall_bits (hall2_bits)
    );

    stop_deglitch u_stop (
        .CLK25MHz, .reset_150mhz,
        .stop_n          (FPGA_STOP_N),
        .stop_n_filtered (stop_n_filtered)
    );

    pwm_trigger_gen u_trigger (
        .CLK25MHz, .reset_150mhz, .adc_sample_valid, .pwm_trigger
    );

    commutation_pwm u_pwm5 (
        .CLK25MHz, .reset_150mhz, .pwm_trigger, .pwm_duty, .pwm_fault, .pwm_brake,
        .hall_uvw       (motor5_hall_uvw),
        .driver_pwm     (motor5_pwm),
        .driver_reset_n (motor5_reset_n)
    );

    wb_regs u_regs (
        .CLK25MHz, .reset_150mhz,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .hall1_bits, .hall2_bits, .stop_n_filtered,
        .driver_fault_n (MOTOR5_FAULT_N),
        .driver_otw_n   (MOTOR5_OTW_N),
        .sw_flt_n, .motor_led, .motor_sw_en, .pwm_duty, .pwm_fault, .pwm_brake
    );

endmodule

// ==== design/wb_regs.sv ====
`timescale 1ns/10ps

module wb_regs (
    input  logic                                       CLK25MHz,
    input  logic                                       reset_150mhz,
    input  logic                                       wb_cyc,
    input  logic                                       wb_stb,
    input  logic                                       wb_we,
    input  logic [1:0]                                 wb_adr,
    input  logic [15:0]                                wb_dat_w,
    output logic [15:0]                                wb_dat_r,
    output logic                                       wb_ack,
    input  logic [phoenix_pkg::HALL1_BITS-1:0]         hall1_bits,
    input  logic [phoenix_pkg::HALL2_BITS-1:0]         hall2_bits,
    input  logic                                       stop_n_filtered,
    input  logic                                       driver_fault_n,
    input  logic                                       driver_otw_n,
    input  logic [phoenix_pkg::NUM_MOTORS-1:0]         sw_flt_n,
    output logic [phoenix_pkg::NUM_MOTORS-1:0]         motor_led,
    output logic [phoenix_pkg::NUM_MOTORS-1:0]         motor_sw_en,
    output logic signed [phoenix_pkg::DUTY_WIDTH-1:0]  pwm_duty,
    output logic                                       pwm_fault,
    output logic                                       pwm_brake
);
    import phoenix_pkg::*;

    logic        req;
    logic        served;
    logic        access;
    logic [2:0]  hall1_uvw;
    logic [2:0]  hall5_uvw;
    logic [15:0] status_word;
    logic [15:0] read_data;

    assign req    = wb_cyc && wb_stb;
    assign access = req && !served;

    // motor 1 is C,B,A of chain 1, motor 5 is H,A,SER of chain 2
    assign hall1_uvw = hall1_bits[2:0];
    assign hall5_uvw = {hall2_bits[HALL2_BITS-1], hall2_bits[1], hall2_bits[0]};

    assign status_word = {2'b00, ~sw_flt_n, ~driver_otw_n, ~driver_fault_n,
                          ~stop_n_filtered, hall5_uvw, hall1_uvw};

    always_comb begin
        case (wb_adr)
            ADDR_CTRL:   read_data = {6'b000000, motor_sw_en, motor_led};
            ADDR_STATUS: read_data = status_word;
            ADDR_DUTY:   read_data = pwm_duty;
            default:     read_data = {14'b0, pwm_brake, pwm_fault};
        endcase
    end

    // single ack per strobe, master must drop stb before the next one
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            served <= 1'b0;
            wb_ack <= 1'b0;
        end else begin
            served <= req;
            wb_ack <= access;
        end
    end

    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            motor_led   <= '1;
            motor_sw_en <= '0;
            pwm_duty    <= '0;
            pwm_fault   <= 1'b0;
            pwm_brake   <= 1'b0;
        end else if (access && wb_we) begin
            case (wb_adr)
                ADDR_CTRL: begin
                    motor_led   <= wb_dat_w[4:0];
                    motor_sw_en <= wb_dat_w[9:5];
                end
                ADDR_DUTY: pwm_duty <= wb_dat_w;
                ADDR_FAULT: begin
                    pwm_fault <= wb_dat_w[0];
                    pwm_brake <= wb_dat_w[1];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK25MHz) begin
        if (access) begin
            wb_dat_r <= read_data;
        end
    end

endmodule

// ==== design/commutation_pwm.sv ====
`timescale 1ns/10ps

module commutation_pwm (
    input  logic                                      CLK25MHz,
    input  logic                                      reset_150mhz,
    input  logic                                      pwm_trigger,
    input  logic signed [phoenix_pkg::DUTY_WIDTH-1:0] pwm_duty,
    input  logic                                      pwm_fault,
    input  logic                                      pwm_brake,
    input  logic [2:0]                                hall_uvw,
    output logic [2:0]                                driver_pwm,
    output logic [2:0]                                driver_reset_n
);
    import phoenix_pkg::*;

    logic [DUTY_WIDTH-1:0] duty_mag;
    logic [11:0]           on_next;
    comm_step_t            hall_step;
    comm_step_t            step_next;
    logic                  active;
    logic [11:0]           period_cnt;
    logic [11:0]           on_cycles;
    comm_step_t            step_q;
    logic                  fault_q;
    logic                  brake_q;
    logic [2:0]            sw_sel;
    logic [2:0]            float_sel;
    logic [2:0]            pwm_next;
    logic [2:0]            reset_n_next;

    // reverse rotation swaps switching and low phases
    function automatic comm_step_t reverse_step(input comm_step_t step);
        case (step)
            step_uv: return step_vu;
            step_uw: return step_wu;
            step_vw: return step_wv;
            step_vu: return step_uv;
            step_wu: return step_uw;
            step_wv: return step_vw;
            default: return step_off;
        endcase
    endfunction

    always_comb begin
        case (hall_uvw)
            3'b101:  hall_step = step_uv;
            3'b100:  hall_step = step_uw;
            3'b110:  hall_step = step_vw;
            3'b010:  hall_step = step_vu;
            3'b011:  hall_step = step_wu;
            3'b001:  hall_step = step_wv;
            default: hall_step = step_off;
        endcase
    end

    assign step_next = pwm_duty[DUTY_WIDTH-1] ? reverse_step(hall_step) : hall_step;
    assign duty_mag  = pwm_duty[DUTY_WIDTH-1] ? $unsigned(-pwm_duty) : $unsigned(pwm_duty);
    assign on_next   = (duty_mag > DUTY_WIDTH'(PWM_MAX_ON_CYCLES)) ? PWM_MAX_ON_CYCLES
                                                                   : duty_mag[11:0];

    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            active     <= 1'b0;
            period_cnt <= '0;
            on_cycles  <= '0;
            step_q     <= step_off;
            fault_q    <= 1'b0;
            brake_q    <= 1'b0;
        end else if (pwm_trigger) begin
            active     <= 1'b1;
            period_cnt <= '0;
            on_cycles  <= on_next;
            step_q     <= step_next;
            fault_q    <= pwm_fault;
            brake_q    <= pwm_brake;
        end else if (period_cnt != PWM_PERIOD_CYCLES - 12'd1) begin
            // holds at the end if the next trigger is late
            period_cnt <= period_cnt + 12'd1;
        end
    end

    // one-hot phase selects, bit order w,v,u
    always_comb begin
        case (step_q)
            step_uv: begin sw_sel = 3'b001; float_sel = 3'b100; end
            step_uw: begin sw_sel = 3'b001; float_sel = 3'b010; end
            step_vw: begin sw_sel = 3'b010; float_sel = 3'b001; end
            step_vu: begin sw_sel = 3'b010; float_sel = 3'b100; end
            step_wu: begin sw_sel = 3'b100; float_sel = 3'b010; end
            step_wv: begin sw_sel = 3'b100; float_sel = 3'b001; end
            default: begin sw_sel = 3'b000; float_sel = 3'b111; end
        endcase
    end

    always_comb begin
        if (!active || fault_q) begin
            pwm_next     = 3'b000;
            reset_n_next = 3'b000;
        end else if (brake_q) begin
            // all low sides on
            pwm_next     = 3'b000;
            reset_n_next = 3'b111;
        end else begin
            pwm_next     = (period_cnt < on_cycles) ? sw_sel : 3'b000;
            reset_n_next = ~float_sel;
        end
    end

    // registered so the gate drivers see clean edges
    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            driver_pwm     <= 3'b000;
            driver_reset_n <= 3'b000;
        end else begin
            driver_pwm     <= pwm_next;
            driver_reset_n <= reset_n_next;
        end
    end

endmodule

// ==== design/pwm_trigger_gen.sv ====
`timescale 1ns/10ps

module pwm_trigger_gen (
    input  logic CLK25MHz,
    input  logic reset_150mhz,
    input  logic adc_sample_valid,
    output logic pwm_trigger
);
    import phoenix_pkg::*;

    logic [4:0] strobe_cnt;

    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            strobe_cnt  <= '0;
            pwm_trigger <= 1'b0;
        end else begin
            pwm_trigger <= 1'b0;
            if (adc_sample_valid) begin
                // every 30th strobe starts a new pwm period
                if (strobe_cnt == TRIGGER_DIVIDE - 5'd1) begin
                    strobe_cnt  <= '0;
                    pwm_trigger <= 1'b1;
                end else begin
                    strobe_cnt <= strobe_cnt + 5'd1;
                end
            end
        end
    end

endmodule

// ==== design/stop_deglitch.sv ====
`timescale 1ns/10ps

module stop_deglitch (
    input  logic CLK25MHz,
    input  logic reset_150mhz,
    input  logic stop_n,
    output logic stop_n_filtered
);
    import phoenix_pkg::*;

    logic [1:0] stop_sync;
    logic [6:0] stable_cnt;

    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            stop_sync       <= 2'b11;
            stable_cnt      <= '0;
            stop_n_filtered <= 1'b1;
        end else begin
            // pin is asynchronous to the board clock
            stop_sync <= {stop_sync[0], stop_n};
            if (stop_sync[1] == stop_n_filtered) begin
                stable_cnt <= '0;
            end else if (stable_cnt == STOP_FILTER_CYCLES - 7'd1) begin
                stable_cnt      <= '0;
                stop_n_filtered <= stop_sync[1];
            end else begin
                stable_cnt <= stable_cnt + 7'd1;
            end
        end
    end

endmodule

// ==== design/hall_shift_reader.sv ====
`timescale 1ns/10ps

module hall_shift_reader #(
    parameter int NUM_BITS = 8
) (
    input  logic                CLK25MHz,
    input  logic                reset_150mhz,
    input  logic                sr_dout,
    output logic                sr_load_n,
    output logic                sr_clk,
    output logic [NUM_BITS-1:0] hall_bits
);

    logic                        loading;
    logic [$clog2(NUM_BITS)-1:0] bit_cnt;
    logic [NUM_BITS-1:0]         shift_reg;

    always_ff @(posedge CLK25MHz or posedge reset_150mhz) begin
        if (reset_150mhz) begin
            sr_load_n <= 1'b1;
            sr_clk    <= 1'b0;
            loading   <= 1'b1;
            bit_cnt   <= '0;
            hall_bits <= '0;
        end else if (loading) begin
            // load pulse is exactly one clock wide
            if (sr_load_n) begin
                sr_load_n <= 1'b0;
            end else begin
                sr_load_n <= 1'b1;
                loading   <= 1'b0;
                bit_cnt   <= '0;
            end
        end else if (!sr_clk) begin
            // sample before the rising edge, sensors are active low
            sr_clk <= 1'b1;
        end else begin
            sr_clk <= 1'b0;
            if (bit_cnt == ($clog2(NUM_BITS))'(NUM_BITS - 1)) begin
                hall_bits <= shift_reg;
                sr_load_n <= 1'b0;
                loading   <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // first bit taken ends up in the msb
    always_ff @(posedge CLK25MHz) begin
        if (!loading && !sr_clk) begin
            shift_reg <= {shift_reg[NUM_BITS-2:0], ~sr_dout};
        end
    end

endmodule

// ==== design/phoenix_pkg.sv ====
package phoenix_pkg;

    // pwm period and the clamp on the on-time, in CLK25MHz cycles
    localparam logic [11:0] PWM_PERIOD_CYCLES = 12'd3000;
    localparam logic [11:0] PWM_MAX_ON_CYCLES = 12'd2985;

    // signed duty register width
    localparam int DUTY_WIDTH = 16;

    // adc sample strobes per pwm period
    localparam logic [4:0] TRIGGER_DIVIDE = 5'd30;

    // stop input must hold a new level this long
    localparam logic [6:0] STOP_FILTER_CYCLES = 7'd125;

    // hall chain lengths, chain 2 also reads its serial input
    localparam int HALL1_BITS = 8;
    localparam int HALL2_BITS = 9;

    localparam int NUM_MOTORS = 5;

    // wishbone word addresses
    localparam logic [1:0] ADDR_CTRL   = 2'd0;
    localparam logic [1:0] ADDR_STATUS = 2'd1;
    localparam logic [1:0] ADDR_DUTY   = 2'd2;
    localparam logic [1:0] ADDR_FAULT  = 2'd3;

    // first letter switches, second letter is held low
    typedef enum logic [2:0] {
        step_uv,
        step_uw,
        step_vw,
        step_vu,
        step_wu,
        step_wv,
        step_off
    } comm_step_t;

endpackage
